/* common/memif_params.svh */
// memory interface widths and depth

`ifndef MEMIF_PARAMS_SVH
`define MEMIF_PARAMS_SVH

// ############################
// cpu side
// ############################

// byte address width of the load/store port
`define MEMIF_ADDR_W 32

// load and store data width
`define MEMIF_DATA_W 32

// ############################
// memory side
// ############################

// one halfword per memory word
`define MEMIF_MEM_W 16

// halfword address width
`define MEMIF_MEM_AW 12

// number of halfwords in the memory
`define MEMIF_MEM_DEPTH (1 << `MEMIF_MEM_AW)

`endif

/* common/memif_pkg.sv */
// memory interface types

`include "memif_params.svh"

package memif_pkg;

  // ############################
  // enumerations
  // ############################

  // access size of a cpu request
  typedef enum logic [1:0] {
    WT_BYTE = 2'd0,
    WT_HALF = 2'd1,
    WT_WORD = 2'd2
  } word_type_e;

  // position of one memory access inside a request
  typedef enum logic [1:0] {
    ACC_FIRST  = 2'd0,
    ACC_MIDDLE = 2'd1,
    ACC_LAST   = 2'd2
  } acc_kind_e;

  // ############################
  // structs
  // ############################

  // one cpu load or store
  typedef struct packed {
    logic                     is_store;
    word_type_e               word_type;
    logic                     is_signed;
    logic [`MEMIF_ADDR_W-1:0] addr;
    logic [`MEMIF_DATA_W-1:0] wdata;
  } cpu_req_t;

  // one halfword memory access
  typedef struct packed {
    logic                     en;
    logic                     we;
    logic [`MEMIF_MEM_AW-1:0] addr;
    // be[0] is bits 7:0, be[1] is bits 15:8
    logic [1:0]               be;
    logic [`MEMIF_MEM_W-1:0]  wdata;
  } mem_cmd_t;

  // where the lanes of one returned halfword go
  typedef struct packed {
    logic [1:0] slot1;
    logic [1:0] slot0;
    logic       use1;
    logic       use0;
    logic       last;
  } rd_tag_t;

  // size and signedness of the running load
  typedef struct packed {
    word_type_e word_type;
    logic       is_signed;
  } load_ctl_t;

endpackage

/* verilog/stage_reg.sv */
// pipeline stage register

`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // valid bit, cleared by reset
  always_ff @(posedge clk) begin
    if (!reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

/* verilog/request_port.sv */
// cpu side four-phase handshake

`timescale 1ns/1ps

`include "memif_params.svh"

module request_port (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpu_req,
  input  memif_pkg::cpu_req_t      cpu_request,
  output logic                     cpu_ack,
  output logic [`MEMIF_DATA_W-1:0] cpu_rdata,
  output logic                     req_valid,
  output memif_pkg::cpu_req_t      req_data,
  input  logic                     op_done,
  input  logic [`MEMIF_DATA_W-1:0] load_result
);

  typedef enum logic [1:0] {
    RP_IDLE = 2'd0,
    RP_BUSY = 2'd1,
    RP_ACK  = 2'd2
  } rp_state_e;

  rp_state_e state;

  // ############################
  // state transitions
  // ############################

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= RP_IDLE;
    end else begin
      case (state)
        RP_IDLE: begin
          // new request only once req and ack are both low
          if (cpu_req) begin
            state <= RP_BUSY;
          end
        end
        RP_BUSY: begin
          if (op_done) begin
            state <= RP_ACK;
          end
        end
        RP_ACK: begin
          // hold ack until the cpu lets go of req
          if (!cpu_req) begin
            state <= RP_IDLE;
          end
        end
        default: state <= RP_IDLE;
      endcase
    end
  end

  // result held for the whole ack phase
  always_ff @(posedge clk) begin
    if (state == RP_BUSY && op_done) begin
      cpu_rdata <= load_result;
    end
  end

  // ############################
  // outputs
  // ############################

  // single cycle pulse, state leaves idle at the next edge
  assign req_valid = (state == RP_IDLE) && cpu_req;
  assign req_data  = cpu_request;

  assign cpu_ack = (state == RP_ACK);

endmodule

/* memory_control/memory_control_fsm.sv */
// access sequencer for the halfword memory

`timescale 1ns/1ps

`include "memif_params.svh"

module memory_control_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  memif_pkg::cpu_req_t  request,
  output memif_pkg::mem_cmd_t  mem_cmd,
  output logic                 tag_valid,
  output memif_pkg::rd_tag_t   tag,
  output memif_pkg::load_ctl_t load_ctl,
  input  logic                 load_done,
  output logic                 op_done
);

  import memif_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_WAIT   = 2'd2
  } fsm_state_e;

  fsm_state_e               state;
  cpu_req_t                 req_q;
  logic [1:0]               acc_idx;
  logic [`MEMIF_MEM_AW-1:0] hw_addr;

  logic [2:0] n_bytes;
  logic [2:0] n_acc;
  acc_kind_e  acc_kind;
  logic       is_last;
  logic [2:0] pos0;
  logic [2:0] pos1;
  logic       use0;
  logic       use1;

  // ############################
  // access planning
  // ############################

  // bytes moved by the request
  always_comb begin
    case (req_q.word_type)
      WT_BYTE: n_bytes = 3'd1;
      WT_HALF: n_bytes = 3'd2;
      WT_WORD: n_bytes = 3'd4;
      default: n_bytes = 3'd4;
    endcase
  end

  // halfwords touched, odd start adds one lane in front
  assign n_acc = (n_bytes + {2'b00, req_q.addr[0]} + 3'd1) >> 1;

  // first, middle or last access
  always_comb begin
    if ({1'b0, acc_idx} == n_acc - 3'd1) begin
      acc_kind = ACC_LAST;
    end else if (acc_idx == 2'd0) begin
      acc_kind = ACC_FIRST;
    end else begin
      acc_kind = ACC_MIDDLE;
    end
  end

  assign is_last = (acc_kind == ACC_LAST);

  // cpu byte index on each lane: 2*k + lane - offset
  // negative wraps to 7, so it falls out of range
  assign pos0 = {acc_idx, 1'b0} - {2'b00, req_q.addr[0]};
  assign pos1 = {acc_idx, 1'b1} - {2'b00, req_q.addr[0]};

  assign use0 = (pos0 < n_bytes);
  assign use1 = (pos1 < n_bytes);

  // ############################
  // state and counters
  // ############################

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= ST_IDLE;
      acc_idx <= 2'd0;
    end else begin
      case (state)
        ST_IDLE: begin
          acc_idx <= 2'd0;
          if (req_valid) begin
            state <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          // one access per cycle, no gaps
          acc_idx <= acc_idx + 2'd1;
          if (is_last) begin
            state <= req_q.is_store ? ST_IDLE : ST_WAIT;
          end
        end
        ST_WAIT: begin
          // last read still in flight to the assembler
          if (load_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request copy and running halfword address
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_valid) begin
      req_q   <= request;
      hw_addr <= request.addr[`MEMIF_MEM_AW:1];
    end else if (state == ST_ACCESS) begin
      hw_addr <= hw_addr + 1'b1;
    end
  end

  // ############################
  // memory command
  // ############################

  always_comb begin
    mem_cmd.en   = (state == ST_ACCESS);
    mem_cmd.we   = (state == ST_ACCESS) && req_q.is_store;
    mem_cmd.addr = hw_addr;
    mem_cmd.be   = {use1, use0};
    // lanes may cross at odd alignment
    mem_cmd.wdata[7:0]  = req_q.wdata[{pos0[1:0], 3'b000} +: 8];
    mem_cmd.wdata[15:8] = req_q.wdata[{pos1[1:0], 3'b000} +: 8];
  end

  // ############################
  // read tags and completion
  // ############################

  assign tag_valid = (state == ST_ACCESS) && !req_q.is_store;

  always_comb begin
    tag.slot0 = pos0[1:0];
    tag.slot1 = pos1[1:0];
    tag.use0  = use0;
    tag.use1  = use1;
    tag.last  = is_last;
  end

  assign load_ctl.word_type = req_q.word_type;
  assign load_ctl.is_signed = req_q.is_signed;

  // stores finish with the last write, loads with the assembler
  assign op_done = (state == ST_ACCESS && is_last && req_q.is_store) ||
                   (state == ST_WAIT && load_done);

endmodule

/* memory_control/load_assembler.sv */
// load result assembly and extension

`timescale 1ns/1ps

`include "memif_params.svh"

module load_assembler (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     tag_valid,
  input  memif_pkg::rd_tag_t       tag,
  input  logic [`MEMIF_MEM_W-1:0]  mem_rdata,
  input  memif_pkg::load_ctl_t     load_ctl,
  output logic [`MEMIF_DATA_W-1:0] load_result,
  output logic                     load_done
);

  import memif_pkg::*;

  // four result byte slots, slot 0 is the lowest byte
  logic [3:0][7:0] acc_q;
  logic [3:0][7:0] merged;

  // ############################
  // byte placement
  // ############################

  // current halfword overlaid on the bytes gathered so far
  always_comb begin
    merged = acc_q;
    if (tag_valid) begin
      if (tag.use0) begin
        merged[tag.slot0] = mem_rdata[7:0];
      end
      if (tag.use1) begin
        merged[tag.slot1] = mem_rdata[15:8];
      end
    end
  end

  // slots cleared once a load completes
  always_ff @(posedge clk) begin
    if (!reset) begin
      acc_q <= '0;
    end else if (tag_valid) begin
      if (tag.last) begin
        acc_q <= '0;
      end else begin
        acc_q <= merged;
      end
    end
  end

  // ############################
  // extension
  // ############################

  always_comb begin
    case (load_ctl.word_type)
      WT_BYTE: begin
        // sign from bit 7
        load_result = {{24{load_ctl.is_signed & merged[0][7]}}, merged[0]};
      end
      WT_HALF: begin
        // sign from bit 15
        load_result = {{16{load_ctl.is_signed & merged[1][7]}}, merged[1], merged[0]};
      end
      default: begin
        load_result = merged;
      end
    endcase
  end

  // pulses with the last returned halfword
  assign load_done = tag_valid && tag.last;

endmodule

/* verilog/mem_interface_top.sv */
// memory interface top level

`timescale 1ns/1ps

`include "memif_params.svh"

module mem_interface_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpu_req,
  input  memif_pkg::cpu_req_t      cpu_request,
  output logic                     cpu_ack,
  output logic [`MEMIF_DATA_W-1:0] cpu_rdata,
  output memif_pkg::mem_cmd_t      mem_cmd,
  input  logic [`MEMIF_MEM_W-1:0]  mem_rdata
);

  import memif_pkg::*;

  // request path
  logic     req_valid;
  cpu_req_t req_data;
  logic     stage_valid;
  cpu_req_t stage_data;

  // read tag path
  logic    tag_valid;
  rd_tag_t tag;
  logic    tag_valid_d;
  rd_tag_t tag_d;

  // completion
  load_ctl_t               load_ctl;
  logic                    load_done;
  logic                    op_done;
  logic [`MEMIF_DATA_W-1:0] load_result;

  // ############################
  // request capture
  // ############################

  request_port request_port_i (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_request (cpu_request),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .req_valid   (req_valid),
    .req_data    (req_data),
    .op_done     (op_done),
    .load_result (load_result)
  );

  stage_reg #(.payload_t(cpu_req_t)) req_stage_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_data   (req_data),
    .out_valid (stage_valid),
    .out_data  (stage_data)
  );

  // ############################
  // sequencing and assembly
  // ############################

  memory_control_fsm memory_control_fsm_i (
    .clk       (clk),
    .reset     (reset),
    .req_valid (stage_valid),
    .request   (stage_data),
    .mem_cmd   (mem_cmd),
    .tag_valid (tag_valid),
    .tag       (tag),
    .load_ctl  (load_ctl),
    .load_done (load_done),
    .op_done   (op_done)
  );

  // matches the one cycle read latency
  stage_reg #(.payload_t(rd_tag_t)) tag_stage_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (tag_valid),
    .in_data   (tag),
    .out_valid (tag_valid_d),
    .out_data  (tag_d)
  );

  load_assembler load_assembler_i (
    .clk         (clk),
    .reset       (reset),
    .tag_valid   (tag_valid_d),
    .tag         (tag_d),
    .mem_rdata   (mem_rdata),
    .load_ctl    (load_ctl),
    .load_result (load_result),
    .load_done   (load_done)
  );

endmodule

/* bench/mem_interface_model.svh */
// reference model of the byte memory

`ifndef MEM_INTERFACE_MODEL_SVH
`define MEM_INTERFACE_MODEL_SVH

// bytes covered by one access size
function automatic int size_bytes(input word_type_e wt);
  case (wt)
    WT_BYTE: return 1;
    WT_HALF: return 2;
    default: return 4;
  endcase
endfunction

// little-endian gather from the shadow image
function automatic logic [`MEMIF_DATA_W-1:0] expected_load(input cpu_req_t r);
  logic [`MEMIF_DATA_W-1:0] value;
  int                       base;
  int                       i;
  value = '0;
  base = int'(r.addr[`MEMIF_MEM_AW:0]);
  for (i = 0; i < size_bytes(r.word_type); i++) begin
    // byte address wraps with the memory
    value[8*i +: 8] = shadow[(base + i) % (2 * `MEMIF_MEM_DEPTH)];
  end
  // top bit of the loaded size is the sign
  if (r.is_signed && r.word_type == WT_BYTE) begin
    value[31:8] = {24{value[7]}};
  end else if (r.is_signed && r.word_type == WT_HALF) begin
    value[31:16] = {16{value[15]}};
  end
  return value;
endfunction

// low data byte lands at the lowest address
function automatic void shadow_store(input cpu_req_t r);
  int base;
  int i;
  base = int'(r.addr[`MEMIF_MEM_AW:0]);
  for (i = 0; i < size_bytes(r.word_type); i++) begin
    shadow[(base + i) % (2 * `MEMIF_MEM_DEPTH)] = r.wdata[8*i +: 8];
  end
endfunction

`endif

/* bench/mem_interface_tb.sv */
// memory interface testbench

`timescale 1ns/1ps

`include "memif_params.svh"

module mem_interface_tb;

  import memif_pkg::*;

  localparam int reset_cycles      = 16;
  // phase 1: 24, phase 2: 15, phase 3: 16
  localparam int directed_requests = 55;
  localparam int random_requests   = 2000;
  localparam int total_requests    = directed_requests + random_requests;

  logic                     clk = 1'b0;
  logic                     reset = 1'b0;
  logic                     cpu_req = 1'b0;
  cpu_req_t                 cpu_request = '0;
  logic                     cpu_ack;
  logic [`MEMIF_DATA_W-1:0] cpu_rdata;
  mem_cmd_t                 mem_cmd;
  logic [`MEMIF_MEM_W-1:0]  mem_rdata = '0;

  // memory model and byte image
  logic [`MEMIF_MEM_W-1:0] mem [0:`MEMIF_MEM_DEPTH-1];
  logic [7:0]              shadow [0:2*`MEMIF_MEM_DEPTH-1];
  // high from req raise until ack seen
  logic                    cmd_open = 1'b0;
  logic [31:0]             lfsr_state = 32'h52bf_9a51;

  `include "mem_interface_model.svh"

  mem_interface_top mem_interface_top_i (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_request (cpu_request),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .mem_cmd     (mem_cmd),
    .mem_rdata   (mem_rdata)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ##############################
  // error handling and random bits
  // ##############################

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_rdata(input cpu_req_t r, input logic [`MEMIF_DATA_W-1:0] got,
                               input logic [`MEMIF_DATA_W-1:0] expected);
    if (got !== expected) begin
      stop_on_error($sformatf("mismatch at %0t: cpu_rdata got %h expected %h (addr %h)",
                              $time, got, expected, r.addr));
    end
  endtask

  task automatic compare_mem_byte(input logic [`MEMIF_MEM_AW:0] byte_addr,
                                  input logic [7:0] got, input logic [7:0] expected);
    if (got !== expected) begin
      stop_on_error($sformatf("mismatch at %0t: mem byte %h got %h expected %h",
                              $time, byte_addr, got, expected));
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_bit()};
    end
    return value;
  endfunction

  // ##############################
  // memory model
  // ##############################

  // odd multiplier keeps every halfword distinct
  function automatic logic [15:0] fill_halfword(input int index);
    logic [31:0] product;
    product = index * 32'h0000_9e37;
    return product[15:0] ^ 16'h3c5a;
  endfunction

  initial begin : memory_fill
    int          i;
    logic [15:0] value;
    for (i = 0; i < `MEMIF_MEM_DEPTH; i++) begin
      value = fill_halfword(i);
      mem[i] <= value;
      shadow[2*i]   = value[7:0];
      shadow[2*i+1] = value[15:8];
    end
  end

  // one cycle read latency, per lane writes
  always @(posedge clk) begin
    if (mem_cmd.en) begin
      // nothing may reach memory between requests
      if (!cmd_open) begin
        stop_on_error("memory command issued while no cpu request was open");
      end
      if (mem_cmd.we) begin
        if (mem_cmd.be[0]) begin
          mem[mem_cmd.addr][7:0] <= mem_cmd.wdata[7:0];
        end
        if (mem_cmd.be[1]) begin
          mem[mem_cmd.addr][15:8] <= mem_cmd.wdata[15:8];
        end
      end else begin
        mem_rdata <= mem[mem_cmd.addr];
      end
    end
  end

  // ##############################
  // requests
  // ##############################

  function automatic cpu_req_t make_request(input logic is_store, input word_type_e wt,
                                            input logic is_signed, input logic [31:0] addr,
                                            input logic [31:0] wdata);
    cpu_req_t r;
    r.is_store  = is_store;
    r.word_type = wt;
    r.is_signed = is_signed;
    r.addr      = addr;
    r.wdata     = wdata;
    return r;
  endfunction

  function automatic cpu_req_t random_request();
    cpu_req_t    r;
    logic [31:0] bits;
    logic [1:0]  wt;
    bits = rand_bits(1);
    r.is_store = bits[0];
    bits = rand_bits(2);
    wt = bits[1:0];
    // code 3 folds into word
    if (wt == 2'd3) begin
      wt = 2'd2;
    end
    r.word_type = word_type_e'(wt);
    bits = rand_bits(1);
    r.is_signed = bits[0];
    r.addr = rand_bits(`MEMIF_MEM_AW + 1);
    r.wdata = rand_bits(32);
    return r;
  endfunction

  // full four-phase cycle with a random release delay
  task automatic run_request(input cpu_req_t r);
    int hold;
    int i;
    @(posedge clk);
    cpu_request <= r;
    cpu_req     <= 1'b1;
    cmd_open    <= 1'b1;
    @(negedge clk);
    while (!cpu_ack) begin
      @(negedge clk);
    end
    cmd_open <= 1'b0;
    if (r.is_store) begin
      shadow_store(r);
    end else begin
      compare_rdata(r, cpu_rdata, expected_load(r));
    end
    hold = int'(rand_bits(3));
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!cpu_ack) begin
        stop_on_error("cpu_ack dropped while cpu_req was still held high");
      end
    end
    @(posedge clk);
    cpu_req <= 1'b0;
    @(negedge clk);
    if (!cpu_ack) begin
      stop_on_error("cpu_ack fell before the DUT could see cpu_req low");
    end
    @(negedge clk);
    if (cpu_ack) begin
      stop_on_error("cpu_ack stayed high one clock after cpu_req dropped");
    end
  endtask

  task automatic store_then_load(input word_type_e wt, input logic [31:0] addr,
                                 input logic is_signed);
    run_request(make_request(1'b1, wt, 1'b0, addr, rand_bits(32)));
    run_request(make_request(1'b0, wt, is_signed, addr, 32'h0));
  endtask

  // every byte of the memory against the image
  task automatic sweep_memory();
    logic [`MEMIF_MEM_AW:0] ba;
    logic [15:0]            half;
    int                     i;
    for (i = 0; i < 2 * `MEMIF_MEM_DEPTH; i++) begin
      ba = i[`MEMIF_MEM_AW:0];
      half = mem[ba[`MEMIF_MEM_AW:1]];
      compare_mem_byte(ba, ba[0] ? half[15:8] : half[7:0], shadow[i]);
    end
  endtask

  // ##############################
  // test sequence
  // ##############################

  initial begin : watchdog
    repeat (reset_cycles + total_requests * 20) @(posedge clk);
    stop_on_error("watchdog expired before all requests completed");
  end

  initial begin : main
    int          k;
    int          w;
    int          s;
    logic [31:0] bits;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b1;

    // aligned store and load back, all sizes
    for (k = 0; k < 4; k++) begin
      for (w = 0; w < 3; w++) begin
        store_then_load(word_type_e'(w), 32'h0100 + k * 32'h0510 + 4 * w, 1'b0);
      end
    end

    // bytes 01 7f ff 80 for sign checks
    run_request(make_request(1'b1, WT_WORD, 1'b0, 32'h0200, 32'h80ff_7f01));
    for (k = 0; k < 4; k++) begin
      for (s = 0; s < 2; s++) begin
        run_request(make_request(1'b0, WT_BYTE, s[0], 32'h0200 + k, 32'h0));
      end
    end
    // half at 1 is odd and negative
    for (k = 0; k < 3; k++) begin
      for (s = 0; s < 2; s++) begin
        run_request(make_request(1'b0, WT_HALF, s[0], 32'h0200 + k, 32'h0));
      end
    end

    // odd and 2 mod 4 offsets
    for (k = 1; k < 4; k++) begin
      for (w = 1; w < 3; w++) begin
        bits = rand_bits(1);
        store_then_load(word_type_e'(w), 32'h0300 + 16 * k + 64 * w + k, bits[0]);
      end
    end
    // wrap past the top halfword, three accesses then two
    store_then_load(WT_WORD, 32'h1fff, 1'b1);
    store_then_load(WT_WORD, 32'h1ffe, 1'b0);
    sweep_memory();

    for (k = 0; k < random_requests; k++) begin
      run_request(random_request());
    end
    sweep_memory();

    $display("TEST PASS");
    $finish;
  end

endmodule

/* sim.f */
+incdir+common
+incdir+bench
common/memif_pkg.sv
verilog/stage_reg.sv
verilog/request_port.sv
memory_control/memory_control_fsm.sv
memory_control/load_assembler.sv
verilog/mem_interface_top.sv
bench/mem_interface_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module mem_interface_tb -Mdir obj_dir -f sim.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "compile failed"
  exit 1
fi

./obj_dir/Vmem_interface_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAIL" "$SIM_LOG"; then
  echo "simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation passed"
exit 0
